// ==== common/sys16_board_pkg.sv ====
/*
 * System 16B board types
 * Board kind used for ROM banking and tile-bank decode, plus the tile-bank register
 */

package sys16_board_pkg;

    // Main board variants
    typedef enum logic [2:0] {
        board_5521,
        board_5704,
        board_5358_small,
        board_5358_large,
        board_korean,
        board_5797
    } board_kind_t;

    // Two 3-bit tile bank halves
    typedef struct packed {
        logic [2:0] hi;
        logic [2:0] lo;
    } tile_bank_t;

endpackage

// ==== common/sys16_bus_pkg.sv ====
/*
 * System 16B bus types
 * CPU bus bundle, chip selects and video memory read data
 */
`include "sys16_macros.svh"

package sys16_bus_pkg;

    // 68000-style bus as seen by the address decoder
    typedef struct packed {
        logic [23:1]               addr;
        logic [`SYS16_DATA_W-1:0]  dout;
        logic                      rnw;
        logic                      asn;
        logic                      udsn;
        logic                      ldsn;
    } cpu_bus_t;

    // Registered chip selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic char_ram;
        logic obj_ram;
        logic pal;
        logic io;
        logic tbank;
    } chip_sel_t;

    // Read data coming back from the video side
    typedef struct packed {
        logic [`SYS16_DATA_W-1:0] char_data;
        logic [`SYS16_DATA_W-1:0] pal_data;
        logic [`SYS16_DATA_W-1:0] obj_data;
    } vid_rdata_t;

endpackage

// ==== common/sys16_macros.svh ====
/*
 * System 16B main board constants
 * Region bit positions, bus widths, I/O offsets and the open-bus value
 */
`ifndef SYS16_MACROS_SVH
`define SYS16_MACROS_SVH

// Bit positions in the region-active vector
`define SYS16_REG_RAM   3
`define SYS16_REG_ORAM  4
`define SYS16_REG_VRAM  5
`define SYS16_REG_PAL   6
`define SYS16_REG_IO    7

`define SYS16_ACTIVE_W  8
`define SYS16_DATA_W    16
`define SYS16_ROM_AW    18
`define SYS16_OPEN_BUS  16'hffff

// Word offsets in the I/O area, taken from address bits 3:1
`define SYS16_IO_SYS    3'd0
`define SYS16_IO_JOY1   3'd1
`define SYS16_IO_JOY2   3'd2
`define SYS16_IO_DIPA   3'd3
`define SYS16_IO_DIPB   3'd4

`endif

// ==== decode/sys16_region_decode.sv ====
/*
 * System 16B region decoder
 * Turns strobes, the region-active vector and board kind into registered chip selects
 */
`timescale 1ns/1ps
`include "sys16_macros.svh"

module sys16_region_decode
    import sys16_bus_pkg::*;
    import sys16_board_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  board_kind_t                 board_kind,
    input  cpu_bus_t                    bus,
    input  logic [`SYS16_ACTIVE_W-1:0]  active,
    output chip_sel_t                   cs
);

    logic       is_5797;
    logic       ds_present;
    logic       decoded;
    logic       rom_region;
    logic       tbank_region;
    chip_sel_t  cs_next;

    assign is_5797 = (board_kind == board_5797);

    // Either byte strobe low
    assign ds_present = !bus.udsn || !bus.ldsn;

    // Reads may start on the address strobe alone
    assign decoded = ds_present || (!bus.asn && bus.rnw);

    // ROM lives in region 0 on the 5797, regions 0 to 2 elsewhere
    assign rom_region = is_5797 ? active[0] : |active[2:0];

    // The 5797 shares region 1 with other devices, the tile bank sits at 0x2000
    always_comb begin
        if (is_5797) begin
            tbank_region = active[1] && (bus.addr[13:12] == 2'd2);
        end else begin
            tbank_region = active[2];
        end
    end

    always_comb begin
        cs_next          = '0;
        cs_next.rom      = rom_region && bus.rnw;
        cs_next.char_ram = active[`SYS16_REG_VRAM] && bus.addr[16];
        cs_next.obj_ram  = active[`SYS16_REG_ORAM];
        cs_next.pal      = active[`SYS16_REG_PAL];
        cs_next.io       = active[`SYS16_REG_IO];
        cs_next.tbank    = tbank_region && !bus.rnw;
        // SDRAM requests need the select to toggle between accesses
        cs_next.vram     = ds_present && active[`SYS16_REG_VRAM] && !bus.addr[16];
        cs_next.ram      = ds_present && active[`SYS16_REG_RAM];
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cs <= '0;
        end else if (decoded) begin
            cs <= cs_next;
        end else begin
            cs <= '0;
        end
    end

endmodule

// ==== decode/sys16_rom_bank.sv ====
/*
 * System 16B ROM banking
 * Builds the ROM word address from the CPU address and active region per board
 */
`timescale 1ns/1ps
`include "sys16_macros.svh"

module sys16_rom_bank
    import sys16_bus_pkg::*;
    import sys16_board_pkg::*;
(
    input  board_kind_t                 board_kind,
    input  cpu_bus_t                    bus,
    input  logic [`SYS16_ACTIVE_W-1:0]  active,
    output logic [`SYS16_ROM_AW:1]      rom_addr
);

    logic [1:0] bank;

    // One-hot ROM region to bank number
    always_comb begin
        case (active[2:0])
            3'b001:  bank = 2'd0;
            3'b010:  bank = 2'd1;
            3'b100:  bank = 2'd2;
            default: bank = 2'd0;
        endcase
    end

    always_comb begin
        case (board_kind)
            board_5797: begin
                rom_addr = bus.addr[18:1];
            end
            board_5358_large: begin
                rom_addr = {bank, bus.addr[16:1]};
            end
            board_5358_small: begin
                rom_addr = {1'b0, bank, bus.addr[15:1]};
            end
            board_korean: begin
                rom_addr = {1'b0, bus.addr[17:1]};
            end
            default: begin
                // 5521 and 5704, 512kB of program ROM
                rom_addr = {bank[0], bus.addr[17:1]};
            end
        endcase
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the System 16B main board testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build/sim.log
mkdir -p build

verilator --binary --timing --assert --top-module sys16_main_tb \
    -f sources.f --Mdir build \
    && ./build/Vsys16_main_tb +verilator+error+limit+1000 > build/sim.log 2>&1

cat build/sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" build/sim.log 2>/dev/null \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

// ==== sim/sys16_main_asserts.sv ====
/*
 * System 16B main board assertions
 * Select exclusivity, read-only ROM, idle clearing and the wait signal
 */
`timescale 1ns/1ps

module sys16_main_asserts
    import sys16_bus_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input cpu_bus_t  bus,
    input chip_sel_t cs,
    input logic      bus_busy
);

    int unsigned onehot_fails = 0;
    int unsigned rom_fails    = 0;
    int unsigned idle_fails   = 0;
    int unsigned busy_fails   = 0;
    int unsigned fail_count;

    assign fail_count = onehot_fails + rom_fails + idle_fails + busy_fails;

    // ROM and tile bank may overlap other devices, the rest may not
    one_device: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cs.ram, cs.vram, cs.char_ram, cs.obj_ram, cs.pal, cs.io}))
    else begin
        $error("several device selects at once: %b", cs);
        onehot_fails++;
    end

    rom_read_only: assert property (@(posedge clk) disable iff (rst)
        !bus.rnw |=> !cs.rom)
    else begin
        $error("ROM selected after a write cycle");
        rom_fails++;
    end

    idle_clears: assert property (@(posedge clk) disable iff (rst)
        (bus.asn && bus.udsn && bus.ldsn) |=> (cs == '0))
    else begin
        $error("selects still set after an idle bus cycle: %b", cs);
        idle_fails++;
    end

    // No wait state without an address strobe
    no_wait_idle: assert property (@(posedge clk) disable iff (rst)
        bus.asn |-> !bus_busy)
    else begin
        $error("bus_busy high with the address strobe released");
        busy_fails++;
    end

endmodule

bind sys16_main sys16_main_asserts asserts_inst (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .bus      ( bus      ),
    .cs       ( cs       ),
    .bus_busy ( bus_busy )
);

// ==== sim/sys16_main_tb.sv ====
/*
 * Testbench for the System 16B main board core
 * LFSR-driven bus cycles checked against the decode, banking and return rules
 */
`timescale 1ns/1ps
`include "sys16_macros.svh"

module sys16_main_tb
    import sys16_bus_pkg::*;
    import sys16_board_pkg::*;
();

    localparam int WAIT_LIMIT = 16;

    logic        clk, rst, ram_ok, rom_ok, service, bus_busy, flip, video_en;
    board_kind_t board_kind;
    cpu_bus_t    bus;
    logic [7:0]  active, joystick1, joystick2, dipsw_a, dipsw_b;
    logic [15:0] ram_data, rom_data, cpu_din;
    logic [3:0]  coin;
    vid_rdata_t  vid_rdata;
    chip_sel_t   cs;
    logic [18:1] rom_addr;
    tile_bank_t  tile_bank;

    // Reference state for the cabinet registers
    tile_bank_t  exp_tile;
    logic        exp_flip, exp_video;
    logic [31:0] lfsr;
    int          errors;

    sys16_main sys16_main_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (expected == actual) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic chip_sel_t expected_cs(input board_kind_t kind, input cpu_bus_t b,
                                              input logic [7:0] act);
        chip_sel_t c;
        logic      ds;
        c  = '0;
        ds = !b.udsn || !b.ldsn;
        if (ds || (!b.asn && b.rnw)) begin
            c.rom      = b.rnw && (kind == board_5797 ? act[0] : |act[2:0]);
            c.ram      = ds && act[`SYS16_REG_RAM];
            c.vram     = ds && act[`SYS16_REG_VRAM] && !b.addr[16];
            c.char_ram = act[`SYS16_REG_VRAM] && b.addr[16];
            c.obj_ram  = act[`SYS16_REG_ORAM];
            c.pal      = act[`SYS16_REG_PAL];
            c.io       = act[`SYS16_REG_IO];
            c.tbank    = !b.rnw && (kind == board_5797 ?
                                    act[1] && b.addr[13:12] == 2'd2 : act[2]);
        end
        return c;
    endfunction

    function automatic logic [7:0] expected_cab(input logic [2:0] offset);
        case (offset)
            `SYS16_IO_SYS:  return {3'b111, service, coin};
            `SYS16_IO_JOY1: return joystick1;
            `SYS16_IO_JOY2: return joystick2;
            `SYS16_IO_DIPA: return dipsw_a;
            `SYS16_IO_DIPB: return dipsw_b;
            default:        return 8'hff;
        endcase
    endfunction

    function automatic logic [15:0] expected_din(input chip_sel_t c, input logic [2:0] offset);
        if (c.ram || c.vram) return ram_data;
        if (c.rom) return rom_data;
        if (c.char_ram) return vid_rdata.char_data;
        if (c.pal) return vid_rdata.pal_data;
        if (c.obj_ram) return vid_rdata.obj_data;
        if (c.io) return {8'hff, expected_cab(offset)};
        return `SYS16_OPEN_BUS;
    endfunction

    function automatic logic [18:1] expected_rom_addr(input board_kind_t kind,
                                                      input logic [23:1] addr,
                                                      input logic [7:0] act);
        logic [1:0] bank;
        bank = act[2:0] == 3'b010 ? 2'd1 : act[2:0] == 3'b100 ? 2'd2 : 2'd0;
        case (kind)
            board_5797:       return addr[18:1];
            board_5358_large: return {bank, addr[16:1]};
            board_5358_small: return {1'b0, bank, addr[15:1]};
            board_korean:     return {1'b0, addr[17:1]};
            default:          return {bank[0], addr[17:1]};
        endcase
    endfunction

    task automatic randomize_sources();
        ram_data            = 16'(rand_bits(16));
        rom_data            = 16'(rand_bits(16));
        vid_rdata.char_data = 16'(rand_bits(16));
        vid_rdata.pal_data  = 16'(rand_bits(16));
        vid_rdata.obj_data  = 16'(rand_bits(16));
        joystick1           = 8'(rand_bits(8));
        joystick2           = 8'(rand_bits(8));
        dipsw_a             = 8'(rand_bits(8));
        dipsw_b             = 8'(rand_bits(8));
        coin                = 4'(rand_bits(4));
        service             = rand_bits(1) != 0;
    endtask

    task automatic start_cycle(input logic rnw, input logic udsn, input logic ldsn,
                               input logic [23:1] addr, input logic [7:0] act);
        bus.addr = addr;
        bus.dout = 16'(rand_bits(16));
        bus.rnw  = rnw;
        bus.asn  = 1'b0;
        bus.udsn = udsn;
        bus.ldsn = ldsn;
        active   = act;
    endtask

    task automatic idle_cycle();
        bus.asn  = 1'b1;
        bus.udsn = 1'b1;
        bus.ldsn = 1'b1;
        bus.rnw  = 1'b1;
        active   = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ready(input string name);
        int cnt;
        cnt = 0;
        while (bus_busy && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (bus_busy) begin
            errors++;
            $display("Timeout in %s: bus_busy still high after %0d cycles", name, cnt);
        end
    endtask

    // One full bus cycle: selects after one clock, data and registers after two
    task automatic access(input string name, input logic rnw, input logic udsn,
                          input logic ldsn, input logic [23:1] addr, input logic [7:0] act);
        chip_sel_t exp_cs;
        start_cycle(rnw, udsn, ldsn, addr, act);
        exp_cs = expected_cs(board_kind, bus, active);
        if (!rnw && !ldsn && exp_cs.tbank) begin
            if (addr[1]) begin
                exp_tile.hi = bus.dout[2:0];
            end else begin
                exp_tile.lo = bus.dout[2:0];
            end
        end
        if (!rnw && !ldsn && exp_cs.io && addr[3:1] == `SYS16_IO_SYS) begin
            exp_video = bus.dout[5];
            exp_flip  = bus.dout[6];
        end
        @(posedge clk);
        #1;
        compare({name, " cs"}, 32'(exp_cs), 32'(cs));
        @(posedge clk);
        #1;
        if (rnw) begin
            compare({name, " cpu_din"}, 32'(expected_din(exp_cs, addr[3:1])), 32'(cpu_din));
        end
        compare({name, " tile_bank"}, 32'(exp_tile), 32'(tile_bank));
        compare({name, " flip"}, 32'(exp_flip), 32'(flip));
        compare({name, " video_en"}, 32'(exp_video), 32'(video_en));
        idle_cycle();
    endtask

    // Read with the memory ok held low for a random number of cycles
    task automatic wait_test(input string name, input logic is_rom);
        int hold;
        hold   = 1 + int'(rand_bits(3));
        ram_ok = is_rom;
        rom_ok = !is_rom;
        start_cycle(1'b1, 1'b0, 1'b0, 23'(rand_bits(23)), is_rom ? 8'h01 : 8'h08);
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            compare({name, " bus_busy"}, 32'd1, 32'(bus_busy));
        end
        ram_data = 16'(rand_bits(16));
        rom_data = 16'(rand_bits(16));
        ram_ok   = 1'b1;
        rom_ok   = 1'b1;
        #1;
        compare({name, " bus_busy after ok"}, 32'd0, 32'(bus_busy));
        wait_ready(name);
        @(posedge clk);
        #1;
        compare({name, " cpu_din"}, 32'(is_rom ? rom_data : ram_data), 32'(cpu_din));
        // Address strobe released while the memory is busy again
        ram_ok = 1'b0;
        rom_ok = 1'b0;
        idle_cycle();
        ram_ok = 1'b1;
        rom_ok = 1'b1;
    endtask

    initial begin
        logic [23:1] addr;
        logic [7:0]  act;
        lfsr       = 32'h0a5f_12f5;
        errors     = 0;
        rst        = 1'b1;
        board_kind = board_5704;
        bus        = '0;
        bus.asn    = 1'b1;
        bus.udsn   = 1'b1;
        bus.ldsn   = 1'b1;
        bus.rnw    = 1'b1;
        active     = '0;
        ram_ok     = 1'b1;
        rom_ok     = 1'b1;
        randomize_sources();
        exp_tile   = '0;
        exp_flip   = 1'b0;
        exp_video  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        compare("reset cs", 32'd0, 32'(cs));
        compare("reset cpu_din", 32'd0, 32'(cpu_din));
        compare("reset video_en", 32'd1, 32'(video_en));

        // Every region, then nothing mapped, on both board families
        // Reads on the 5797 pass use the address strobe alone
        for (int k = 0; k < 2; k++) begin
            board_kind = k != 0 ? board_5797 : board_5704;
            for (int r = 0; r <= 8; r++) begin
                for (int v = 0; v < 2; v++) begin
                    addr     = 23'(rand_bits(23));
                    addr[16] = v[0];
                    if (v != 0) begin
                        addr[13:12] = 2'd2;
                    end
                    act = r == 8 ? 8'h00 : 8'(1 << r);
                    randomize_sources();
                    access("region read", 1'b1, k[0], k[0], addr, act);
                    access("region write", 1'b0, 1'b0, 1'b0, addr, act);
                    addr[1] = !addr[1];
                    access("low byte write", 1'b0, 1'b1, 1'b0, addr, act);
                    access("upper byte write", 1'b0, 1'b0, 1'b1, addr, act);
                end
            end
        end

        // ROM address is combinational, checked with the bus idle
        for (int k = 0; k < 6; k++) begin
            board_kind = board_kind_t'(k);
            for (int r = 0; r < 8; r++) begin
                bus.addr = 23'(rand_bits(23));
                active   = 8'(1 << r);
                #1;
                compare("rom bank", 32'(expected_rom_addr(board_kind, bus.addr, active)),
                        32'(rom_addr));
                @(posedge clk);
                #1;
            end
        end
        active = '0;

        board_kind = board_5704;
        for (int i = 0; i < 3; i++) begin
            wait_test("ram wait", 1'b0);
            wait_test("rom wait", 1'b1);
        end

        // Control writes land on offset 0, reads sweep the I/O offsets
        for (int i = 0; i < 6; i++) begin
            randomize_sources();
            addr = {20'(rand_bits(20)), 3'(i)};
            access("cabinet write", 1'b0, 1'b1, 1'b0, {addr[23:4], 3'd0}, 8'h80);
            access("cabinet read", 1'b1, 1'b0, 1'b0, addr, 8'h80);
        end

        $display("Check errors: %0d, assertion failures: %0d",
                 errors, sys16_main_inst.asserts_inst.fail_count);
        if (errors == 0 && sys16_main_inst.asserts_inst.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== source/sys16_cabinet_io.sv ====
/*
 * System 16B cabinet I/O
 * Tile-bank register, input read mux and the flip/video-enable control latch
 */
`timescale 1ns/1ps
`include "sys16_macros.svh"

module sys16_cabinet_io
    import sys16_bus_pkg::*;
    import sys16_board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    input  chip_sel_t   cs,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [3:0]  coin,
    input  logic        service,
    output logic [7:0]  cab_dout,
    output tile_bank_t  tile_bank,
    output logic        flip,
    output logic        video_en
);

    logic lds_wr;

    assign lds_wr = !bus.rnw && !bus.ldsn;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
            flip      <= 1'b0;
            video_en  <= 1'b1;
        end else begin
            if (cs.tbank && lds_wr) begin
                if (bus.addr[1]) begin
                    tile_bank.hi <= bus.dout[2:0];
                end else begin
                    tile_bank.lo <= bus.dout[2:0];
                end
            end
            if (cs.io && lds_wr && bus.addr[3:1] == `SYS16_IO_SYS) begin
                video_en <= bus.dout[5];
                flip     <= bus.dout[6];
            end
        end
    end

    // Unused offsets read back as pulled-up lines
    always_comb begin
        case (bus.addr[3:1])
            `SYS16_IO_SYS:  cab_dout = {3'b111, service, coin};
            `SYS16_IO_JOY1: cab_dout = joystick1;
            `SYS16_IO_JOY2: cab_dout = joystick2;
            `SYS16_IO_DIPA: cab_dout = dipsw_a;
            `SYS16_IO_DIPB: cab_dout = dipsw_b;
            default:        cab_dout = 8'hff;
        endcase
    end

endmodule

// ==== source/sys16_main.sv ====
/*
 * System 16B main board core
 * Region decode, ROM banking, cabinet I/O and CPU read-data return
 */
`timescale 1ns/1ps
`include "sys16_macros.svh"

module sys16_main
    import sys16_bus_pkg::*;
    import sys16_board_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  board_kind_t                 board_kind,

    // CPU bus and mapper result
    input  cpu_bus_t                    bus,
    input  logic [`SYS16_ACTIVE_W-1:0]  active,

    // Memories
    input  logic [`SYS16_DATA_W-1:0]    ram_data,
    input  logic [`SYS16_DATA_W-1:0]    rom_data,
    input  logic                        ram_ok,
    input  logic                        rom_ok,
    input  vid_rdata_t                  vid_rdata,

    // Cabinet inputs
    input  logic [7:0]                  joystick1,
    input  logic [7:0]                  joystick2,
    input  logic [7:0]                  dipsw_a,
    input  logic [7:0]                  dipsw_b,
    input  logic [3:0]                  coin,
    input  logic                        service,

    output chip_sel_t                   cs,
    output logic [`SYS16_ROM_AW:1]      rom_addr,
    output logic [`SYS16_DATA_W-1:0]    cpu_din,
    output logic                        bus_busy,
    output logic                        flip,
    output logic                        video_en,
    output tile_bank_t                  tile_bank
);

    logic [7:0] cab_dout;

    sys16_region_decode region_decode_inst (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .board_kind ( board_kind ),
        .bus        ( bus        ),
        .active     ( active     ),
        .cs         ( cs         )
    );

    sys16_rom_bank rom_bank_inst (
        .board_kind ( board_kind ),
        .bus        ( bus        ),
        .active     ( active     ),
        .rom_addr   ( rom_addr   )
    );

    sys16_cabinet_io cabinet_io_inst (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .bus        ( bus        ),
        .cs         ( cs         ),
        .joystick1  ( joystick1  ),
        .joystick2  ( joystick2  ),
        .dipsw_a    ( dipsw_a    ),
        .dipsw_b    ( dipsw_b    ),
        .coin       ( coin       ),
        .service    ( service    ),
        .cab_dout   ( cab_dout   ),
        .tile_bank  ( tile_bank  ),
        .flip       ( flip       ),
        .video_en   ( video_en   )
    );

    sys16_rdata_return rdata_return_inst (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cs         ( cs         ),
        .ram_data   ( ram_data   ),
        .rom_data   ( rom_data   ),
        .vid_rdata  ( vid_rdata  ),
        .cab_dout   ( cab_dout   ),
        .ram_ok     ( ram_ok     ),
        .rom_ok     ( rom_ok     ),
        .asn        ( bus.asn    ),
        .cpu_din    ( cpu_din    ),
        .bus_busy   ( bus_busy   )
    );

endmodule

// ==== source/sys16_rdata_return.sv ====
/*
 * System 16B read-data return
 * Registered CPU read mux with open-bus default and the SDRAM wait signal
 */
`timescale 1ns/1ps
`include "sys16_macros.svh"

module sys16_rdata_return
    import sys16_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  chip_sel_t                 cs,
    input  logic [`SYS16_DATA_W-1:0]  ram_data,
    input  logic [`SYS16_DATA_W-1:0]  rom_data,
    input  vid_rdata_t                vid_rdata,
    input  logic [7:0]                cab_dout,
    input  logic                      ram_ok,
    input  logic                      rom_ok,
    input  logic                      asn,
    output logic [`SYS16_DATA_W-1:0]  cpu_din,
    output logic                      bus_busy
);

    logic mem_ok;
    logic mem_cs;

    // ROM waits on its own ok, RAM and VRAM share the SDRAM bank ok
    assign mem_ok = cs.rom ? rom_ok : ram_ok;
    assign mem_cs = cs.rom || cs.ram || cs.vram;

    // No wait once the address strobe is gone
    assign bus_busy = !asn && mem_cs && !mem_ok;

    // Sampled every cycle, so the value after ok rises is the one the CPU takes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else if (cs.ram || cs.vram) begin
            cpu_din <= ram_data;
        end else if (cs.rom) begin
            cpu_din <= rom_data;
        end else if (cs.char_ram) begin
            cpu_din <= vid_rdata.char_data;
        end else if (cs.pal) begin
            cpu_din <= vid_rdata.pal_data;
        end else if (cs.obj_ram) begin
            cpu_din <= vid_rdata.obj_data;
        end else if (cs.io) begin
            cpu_din <= {8'hff, cab_dout};
        end else begin
            cpu_din <= `SYS16_OPEN_BUS;
        end
    end

endmodule

// ==== sources.f ====
+incdir+common
common/sys16_bus_pkg.sv
common/sys16_board_pkg.sv
decode/sys16_region_decode.sv
decode/sys16_rom_bank.sv
source/sys16_cabinet_io.sv
source/sys16_rdata_return.sv
source/sys16_main.sv
sim/sys16_main_asserts.sv
sim/sys16_main_tb.sv
